/* verilog/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  localparam int DATA_W    = 32;
  localparam int ADDR_W    = 32;
  localparam int MEM_WORDS = 256;
  localparam int MEM_IDX_W = 8;   // word index taken from address bits 9:2.

  // bit positions in the two-bit operation select.
  localparam int OPT_LOAD  = 0;
  localparam int OPT_STORE = 1;

  // access size in funct3[1:0].
  localparam logic [1:0] F3_BYTE = 2'd0;
  localparam logic [1:0] F3_HALF = 2'd1;
  localparam logic [1:0] F3_WORD = 2'd2;

  localparam int F3_UNSIGNED = 2;   // funct3 bit that selects zero extension.

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // master FSM encoding.
  localparam int ST_W = 3;
  localparam logic [ST_W-1:0] ST_IDLE  = 3'd0;
  localparam logic [ST_W-1:0] ST_RADDR = 3'd1;
  localparam logic [ST_W-1:0] ST_RDATA = 3'd2;
  localparam logic [ST_W-1:0] ST_WADDR = 3'd3;
  localparam logic [ST_W-1:0] ST_WRESP = 3'd4;

  // one memory word, seen whole or as byte lanes (lane 0 is the low byte).
  typedef union packed {
    logic [DATA_W-1:0]  word;
    logic [3:0][7:0]    lanes;
  } mem_word_u;

endpackage

`default_nettype wire

/* verilog/lsu_req_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_req_decode import lsu_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic [1:0]        lsu_opt_i,
  input  logic [2:0]        funct3_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] store_data_i,
  input  logic              ex_to_wb_i,
  input  logic              done_i,
  output logic              acc_valid_o,
  output logic              acc_write_o,
  output logic [ADDR_W-1:0] acc_addr_o,
  output mem_word_u         acc_wdata_o,
  output logic [3:0]        acc_strb_o,
  output logic [1:0]        lane_o,
  output logic [2:0]        load_f3_o,
  output logic              stall_o,
  output logic              finished_o
);

  logic       req;
  logic       busy;
  logic       start;
  logic [3:0] size_mask;
  mem_word_u  placed;

  assign req     = lsu_opt_i[OPT_LOAD] | lsu_opt_i[OPT_STORE];
  assign start   = req & ~finished_o & ~busy;   // one access per request.
  assign stall_o = req & ~finished_o;

  always_comb begin
    case (funct3_i[1:0])
      F3_BYTE: size_mask = 4'b0001;
      F3_HALF: size_mask = 4'b0011;
      F3_WORD: size_mask = 4'b1111;
      default: size_mask = 4'b0000;
    endcase
  end

  // replicate narrow store data so every lane carries it.
  always_comb begin
    placed.word = store_data_i;
    for (int l = 0; l < 4; l++) begin
      if (funct3_i[1:0] == F3_BYTE)
        placed.lanes[l] = store_data_i[7:0];
      else if (funct3_i[1:0] == F3_HALF)
        placed.lanes[l] = (l % 2 == 1) ? store_data_i[15:8] : store_data_i[7:0];
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      acc_write_o <= lsu_opt_i[OPT_STORE];
      acc_addr_o  <= {addr_i[ADDR_W-1:2], 2'b00};
      acc_wdata_o <= placed;
      acc_strb_o  <= size_mask << addr_i[1:0];
      lane_o      <= addr_i[1:0];
      load_f3_o   <= funct3_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      acc_valid_o <= 1'b0;
      busy        <= 1'b0;
      finished_o  <= 1'b0;
    end else begin
      acc_valid_o <= start;
      if (start)
        busy <= 1'b1;
      else if (done_i)
        busy <= 1'b0;
      if (done_i)
        finished_o <= 1'b1;
      else if (ex_to_wb_i)
        finished_o <= 1'b0;   // pipeline took the result.
    end
  end

endmodule

`default_nettype wire

/* verilog/lsu_axil_master.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_axil_master import lsu_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic              acc_valid_i,
  input  logic              acc_write_i,
  input  logic [ADDR_W-1:0] acc_addr_i,
  input  mem_word_u         acc_wdata_i,
  input  logic [3:0]        acc_strb_i,
  output logic              done_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic [ADDR_W-1:0] m_araddr_o,
  output logic              m_arvalid_o,
  input  logic              m_arready_i,
  input  logic [DATA_W-1:0] m_rdata_i,
  input  logic [1:0]        m_rresp_i,
  input  logic              m_rvalid_i,
  output logic              m_rready_o,
  output logic [ADDR_W-1:0] m_awaddr_o,
  output logic              m_awvalid_o,
  input  logic              m_awready_i,
  output logic [DATA_W-1:0] m_wdata_o,
  output logic [3:0]        m_wstrb_o,
  output logic              m_wvalid_o,
  input  logic              m_wready_i,
  input  logic [1:0]        m_bresp_i,
  input  logic              m_bvalid_i,
  output logic              m_bready_o
);

  logic [ST_W-1:0]   state;
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] rd_word;
  logic              r_fire;
  logic              b_fire;
  logic              aw_left;
  logic              w_left;

  assign m_rready_o = (state == ST_RDATA);
  assign m_bready_o = (state == ST_WRESP);
  assign r_fire     = m_rvalid_i & m_rready_o;
  assign b_fire     = m_bvalid_i & m_bready_o;
  assign done_o     = r_fire | b_fire;

  // an error response reads as zero.
  assign rd_word = (m_rresp_i == AXI_RESP_OKAY) ? m_rdata_i : '0;
  assign rdata_o = m_rready_o ? rd_word : rdata_q;   // live during the R transfer.

  // channels still owed after this edge.
  assign aw_left = m_awvalid_o & ~m_awready_i;
  assign w_left  = m_wvalid_o & ~m_wready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= ST_IDLE;
      m_arvalid_o <= 1'b0;
      m_awvalid_o <= 1'b0;
      m_wvalid_o  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (acc_valid_i) begin
            if (acc_write_i) begin
              state       <= ST_WADDR;
              m_awvalid_o <= 1'b1;
              m_wvalid_o  <= 1'b1;
            end else begin
              state       <= ST_RADDR;
              m_arvalid_o <= 1'b1;
            end
          end
        end
        ST_RADDR: begin
          if (m_arready_i) begin
            m_arvalid_o <= 1'b0;
            state       <= ST_RDATA;
          end
        end
        ST_RDATA: begin
          if (m_rvalid_i)
            state <= ST_IDLE;
        end
        ST_WADDR: begin
          if (m_awready_i)
            m_awvalid_o <= 1'b0;   // aw and w may land on different edges.
          if (m_wready_i)
            m_wvalid_o <= 1'b0;
          if (!aw_left && !w_left)
            state <= ST_WRESP;
        end
        ST_WRESP: begin
          if (m_bvalid_i)
            state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == ST_IDLE && acc_valid_i) begin
      m_araddr_o <= acc_addr_i;
      m_awaddr_o <= acc_addr_i;
      m_wdata_o  <= acc_wdata_i.word;
      m_wstrb_o  <= acc_strb_i;
    end
    if (r_fire)
      rdata_q <= rd_word;
    else if (b_fire)
      rdata_q <= DATA_W'(m_bresp_i);   // write status code.
  end

endmodule

`default_nettype wire

/* verilog/lsu_load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align import lsu_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic              done_i,
  input  logic              load_i,
  input  logic [1:0]        lane_i,
  input  logic [2:0]        load_f3_i,
  input  logic [DATA_W-1:0] rdata_i,
  output logic [DATA_W-1:0] result_o
);

  mem_word_u         word;
  logic [7:0]        byte_sel;
  logic [15:0]       half_sel;
  logic              sext;
  logic [DATA_W-1:0] extended;

  assign word     = mem_word_u'(rdata_i);
  assign byte_sel = word.lanes[lane_i];
  assign half_sel = {word.lanes[{lane_i[1], 1'b1}], word.lanes[{lane_i[1], 1'b0}]};
  assign sext     = ~load_f3_i[F3_UNSIGNED];

  always_comb begin
    case (load_f3_i[1:0])
      F3_BYTE: extended = {{(DATA_W-8){sext & byte_sel[7]}}, byte_sel};
      F3_HALF: extended = {{(DATA_W-16){sext & half_sel[15]}}, half_sel};
      default: extended = word.word;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset)
      result_o <= '0;
    else if (done_i && load_i)
      result_o <= extended;   // stores leave the last result alone.
  end

endmodule

`default_nettype wire

/* verilog/axil_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_sram import lsu_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic [ADDR_W-1:0] s_araddr_i,
  input  logic              s_arvalid_i,
  output logic              s_arready_o,
  output logic [DATA_W-1:0] s_rdata_o,
  output logic [1:0]        s_rresp_o,
  output logic              s_rvalid_o,
  input  logic              s_rready_i,
  input  logic [ADDR_W-1:0] s_awaddr_i,
  input  logic              s_awvalid_i,
  output logic              s_awready_o,
  input  logic [DATA_W-1:0] s_wdata_i,
  input  logic [3:0]        s_wstrb_i,
  input  logic              s_wvalid_i,
  output logic              s_wready_o,
  output logic [1:0]        s_bresp_o,
  output logic              s_bvalid_o,
  input  logic              s_bready_i
);

  mem_word_u            mem [MEM_WORDS];
  logic                 aw_got;
  logic                 w_got;
  logic [MEM_IDX_W-1:0] aw_idx_q;
  logic [DATA_W-1:0]    w_data_q;
  logic [3:0]           w_strb_q;
  logic                 ar_fire;
  logic                 aw_fire;
  logic                 w_fire;
  logic                 wr_go;
  logic [MEM_IDX_W-1:0] wr_idx;
  mem_word_u            wr_data;
  logic [3:0]           wr_strb;

  assign s_arready_o = ~s_rvalid_o;
  assign s_awready_o = ~aw_got & ~s_bvalid_o;
  assign s_wready_o  = ~w_got & ~s_bvalid_o;
  assign s_rresp_o   = AXI_RESP_OKAY;
  assign s_bresp_o   = AXI_RESP_OKAY;

  assign ar_fire = s_arvalid_i & s_arready_o;
  assign aw_fire = s_awvalid_i & s_awready_o;
  assign w_fire  = s_wvalid_i & s_wready_o;

  // write once both halves are in, taking whichever one arrives now live.
  assign wr_go   = (aw_got | aw_fire) & (w_got | w_fire);
  assign wr_idx  = aw_got ? aw_idx_q : s_awaddr_i[MEM_IDX_W+1:2];
  assign wr_data = mem_word_u'(w_got ? w_data_q : s_wdata_i);
  assign wr_strb = w_got ? w_strb_q : s_wstrb_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      s_rvalid_o <= 1'b0;
      s_bvalid_o <= 1'b0;
      aw_got     <= 1'b0;
      w_got      <= 1'b0;
    end else begin
      if (ar_fire)
        s_rvalid_o <= 1'b1;
      else if (s_rready_i)
        s_rvalid_o <= 1'b0;
      if (wr_go) begin
        aw_got     <= 1'b0;
        w_got      <= 1'b0;
        s_bvalid_o <= 1'b1;
      end else begin
        if (aw_fire)
          aw_got <= 1'b1;
        if (w_fire)
          w_got <= 1'b1;
        if (s_bready_i)
          s_bvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (aw_fire)
      aw_idx_q <= s_awaddr_i[MEM_IDX_W+1:2];
    if (w_fire) begin
      w_data_q <= s_wdata_i;
      w_strb_q <= s_wstrb_i;
    end
    if (ar_fire)
      s_rdata_o <= mem[s_araddr_i[MEM_IDX_W+1:2]].word;   // address wraps.
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < MEM_WORDS; i++)
        mem[i] <= '0;
    end else if (wr_go) begin
      for (int l = 0; l < 4; l++)
        if (wr_strb[l])
          mem[wr_idx].lanes[l] <= wr_data.lanes[l];
    end
  end

endmodule

`default_nettype wire

/* verilog/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic [1:0]        lsu_opt_i,
  input  logic [2:0]        funct3_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] store_data_i,
  input  logic              ex_to_wb_i,
  output logic              stall_o,
  output logic              finished_o,
  output logic [DATA_W-1:0] result_o
);

  logic              acc_valid;
  logic              acc_write;
  logic [ADDR_W-1:0] acc_addr;
  mem_word_u         acc_wdata;
  logic [3:0]        acc_strb;
  logic [1:0]        lane;
  logic [2:0]        load_f3;
  logic              done;
  logic [DATA_W-1:0] rdata;

  // axi4-lite between master and sram.
  logic [ADDR_W-1:0] axi_araddr;
  logic              axi_arvalid;
  logic              axi_arready;
  logic [DATA_W-1:0] axi_rdata;
  logic [1:0]        axi_rresp;
  logic              axi_rvalid;
  logic              axi_rready;
  logic [ADDR_W-1:0] axi_awaddr;
  logic              axi_awvalid;
  logic              axi_awready;
  logic [DATA_W-1:0] axi_wdata;
  logic [3:0]        axi_wstrb;
  logic              axi_wvalid;
  logic              axi_wready;
  logic [1:0]        axi_bresp;
  logic              axi_bvalid;
  logic              axi_bready;

  lsu_req_decode u_decode (
    .clock        (clock),        .reset       (reset),
    .lsu_opt_i    (lsu_opt_i),    .funct3_i    (funct3_i),
    .addr_i       (addr_i),       .store_data_i(store_data_i),
    .ex_to_wb_i   (ex_to_wb_i),   .done_i      (done),
    .acc_valid_o  (acc_valid),    .acc_write_o (acc_write),
    .acc_addr_o   (acc_addr),     .acc_wdata_o (acc_wdata),
    .acc_strb_o   (acc_strb),     .lane_o      (lane),
    .load_f3_o    (load_f3),      .stall_o     (stall_o),
    .finished_o   (finished_o)
  );

  lsu_axil_master u_master (
    .clock       (clock),        .reset       (reset),
    .acc_valid_i (acc_valid),    .acc_write_i (acc_write),
    .acc_addr_i  (acc_addr),     .acc_wdata_i (acc_wdata),
    .acc_strb_i  (acc_strb),     .done_o      (done),
    .rdata_o     (rdata),
    .m_araddr_o  (axi_araddr),   .m_arvalid_o (axi_arvalid),  .m_arready_i (axi_arready),
    .m_rdata_i   (axi_rdata),    .m_rresp_i   (axi_rresp),
    .m_rvalid_i  (axi_rvalid),   .m_rready_o  (axi_rready),
    .m_awaddr_o  (axi_awaddr),   .m_awvalid_o (axi_awvalid),  .m_awready_i (axi_awready),
    .m_wdata_o   (axi_wdata),    .m_wstrb_o   (axi_wstrb),
    .m_wvalid_o  (axi_wvalid),   .m_wready_i  (axi_wready),
    .m_bresp_i   (axi_bresp),    .m_bvalid_i  (axi_bvalid),   .m_bready_o  (axi_bready)
  );

  lsu_load_align u_align (
    .clock     (clock),      .reset     (reset),
    .done_i    (done),       .load_i    (~acc_write),
    .lane_i    (lane),       .load_f3_i (load_f3),
    .rdata_i   (rdata),      .result_o  (result_o)
  );

  axil_sram u_sram (
    .clock       (clock),        .reset       (reset),
    .s_araddr_i  (axi_araddr),   .s_arvalid_i (axi_arvalid),  .s_arready_o (axi_arready),
    .s_rdata_o   (axi_rdata),    .s_rresp_o   (axi_rresp),
    .s_rvalid_o  (axi_rvalid),   .s_rready_i  (axi_rready),
    .s_awaddr_i  (axi_awaddr),   .s_awvalid_i (axi_awvalid),  .s_awready_o (axi_awready),
    .s_wdata_i   (axi_wdata),    .s_wstrb_i   (axi_wstrb),
    .s_wvalid_i  (axi_wvalid),   .s_wready_o  (axi_wready),
    .s_bresp_o   (axi_bresp),    .s_bvalid_o  (axi_bvalid),   .s_bready_i  (axi_bready)
  );

endmodule

`default_nettype wire

/* tb/lsu_props.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_props import lsu_pkg::*; (
  input logic              clock,
  input logic              reset,
  input logic [1:0]        lsu_opt_i,
  input logic [2:0]        funct3_i,
  input logic [ADDR_W-1:0] addr_i,
  input logic              finished_i,
  input logic              done_i,
  input logic [ADDR_W-1:0] araddr_i,
  input logic              arvalid_i,
  input logic              arready_i,
  input logic [DATA_W-1:0] rdata_i,
  input logic              rvalid_i,
  input logic              rready_i,
  input logic [ADDR_W-1:0] awaddr_i,
  input logic              awvalid_i,
  input logic              awready_i,
  input logic [DATA_W-1:0] wdata_i,
  input logic [3:0]        wstrb_i,
  input logic              wvalid_i,
  input logic              wready_i,
  input logic              bvalid_i,
  input logic              bready_i
);

  int fail_count = 0;   // number of failed assertions.

  ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else begin
      $error("ar channel changed before arready");
      fail_count++;
    end

  aw_hold: assert property (@(posedge clock) disable iff (reset)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
    else begin
      $error("aw channel changed before awready");
      fail_count++;
    end

  w_hold: assert property (@(posedge clock) disable iff (reset)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
    else begin
      $error("w channel changed before wready");
      fail_count++;
    end

  r_hold: assert property (@(posedge clock) disable iff (reset)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else begin
      $error("r channel changed before rready");
      fail_count++;
    end

  b_hold: assert property (@(posedge clock) disable iff (reset)
    bvalid_i && !bready_i |=> bvalid_i)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  reset_quiet: assert property (@(posedge clock)
    reset |=> !(arvalid_i || awvalid_i || wvalid_i || rvalid_i || bvalid_i))
    else begin
      $error("axi valid high during reset");
      fail_count++;
    end

  addr_aligned: assert property (@(posedge clock) disable iff (reset)
    (lsu_opt_i != 2'b00 && !finished_i) |->
      !((funct3_i[1:0] == F3_HALF && addr_i[0]) ||
        (funct3_i[1:0] == F3_WORD && addr_i[1:0] != 2'b00)))
    else begin
      $error("misaligned halfword or word request");
      fail_count++;
    end

  // a new access may only complete once the held result was retired.
  finish_once: assert property (@(posedge clock) disable iff (reset)
    done_i |-> !finished_i)
    else begin
      $error("access completed while a finished result was still held");
      fail_count++;
    end

endmodule

bind lsu_top lsu_props u_props (
  .clock      (clock),
  .reset      (reset),
  .lsu_opt_i  (lsu_opt_i),
  .funct3_i   (funct3_i),
  .addr_i     (addr_i),
  .finished_i (finished_o),
  .done_i     (done),
  .araddr_i   (axi_araddr),
  .arvalid_i  (axi_arvalid),
  .arready_i  (axi_arready),
  .rdata_i    (axi_rdata),
  .rvalid_i   (axi_rvalid),
  .rready_i   (axi_rready),
  .awaddr_i   (axi_awaddr),
  .awvalid_i  (axi_awvalid),
  .awready_i  (axi_awready),
  .wdata_i    (axi_wdata),
  .wstrb_i    (axi_wstrb),
  .wvalid_i   (axi_wvalid),
  .wready_i   (axi_wready),
  .bvalid_i   (axi_bvalid),
  .bready_i   (axi_bready)
);

`default_nettype wire

/* tb/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

  logic              clock;
  logic              reset;
  logic [1:0]        lsu_opt;
  logic [2:0]        funct3;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] store_data;
  logic              ex_to_wb;
  logic              stall;
  logic              finished;
  logic [DATA_W-1:0] result;

  logic [7:0]        shadow [MEM_WORDS*4];   // byte image of the sram.
  logic              exp_load;
  logic [DATA_W-1:0] exp_result;
  logic              fin_prev;
  int                loads;
  int                checked;

  lsu_top UUT (
    .clock        (clock),
    .reset        (reset),
    .lsu_opt_i    (lsu_opt),
    .funct3_i     (funct3),
    .addr_i       (addr),
    .store_data_i (store_data),
    .ex_to_wb_i   (ex_to_wb),
    .stall_o      (stall),
    .finished_o   (finished),
    .result_o     (result)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic word_compare(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic flag_compare(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
  endtask

  // little-endian load from the byte image, extended per funct3.
  function automatic logic [DATA_W-1:0] ref_load(input logic [ADDR_W-1:0] a,
                                                 input logic [2:0] f3);
    logic [9:0]  base;
    logic [15:0] half;
    logic        fill;
    base = a[9:0];
    half = {shadow[base + 10'd1], shadow[base]};
    case (f3[1:0])
      F3_BYTE: begin
        fill = ~f3[F3_UNSIGNED] & shadow[base][7];
        return {{24{fill}}, shadow[base]};
      end
      F3_HALF: begin
        fill = ~f3[F3_UNSIGNED] & half[15];
        return {{16{fill}}, half};
      end
      default: return {shadow[base + 10'd3], shadow[base + 10'd2], half};
    endcase
  endfunction

  task automatic present_op(input logic [1:0] opt, input logic [2:0] f3,
                            input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    logic [9:0] idx;
    lsu_opt    <= opt;
    funct3     <= f3;
    addr       <= a;
    store_data <= d;
    exp_load = opt[OPT_LOAD];
    if (opt[OPT_LOAD]) begin
      exp_result = ref_load(a, f3);
      loads++;
    end else begin
      for (int i = 0; i < 4; i++) begin
        idx = a[9:0] + 10'(i);
        if (i < (1 << f3[1:0]))
          shadow[idx] = d[8*i +: 8];
      end
    end
  endtask

  task automatic await_finish();
    int n;
    n = 0;
    @(negedge clock);
    while (!finished && n < 20) begin
      flag_compare("stall_o", stall, 1'b1);
      @(negedge clock);
      n++;
    end
    if (!finished)
      abort_run("finished_o did not rise within 20 cycles of the request");
    flag_compare("stall_o", stall, 1'b0);
  endtask

  // pipeline holds off for 0 to 5 cycles before taking the result.
  task automatic hold_result();
    logic [DATA_W-1:0] held;
    int                gap;
    held = result;
    gap  = $urandom_range(5, 0);
    repeat (gap) begin
      @(negedge clock);
      flag_compare("finished_o", finished, 1'b1);
      word_compare("result_o", result, held);
    end
  endtask

  task automatic issue(input logic [1:0] opt, input logic [2:0] f3,
                       input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                       input logic chained);
    @(posedge clock);
    ex_to_wb <= chained;   // a chained op retires the previous one on this edge.
    present_op(opt, f3, a, d);
    if (chained) begin
      @(posedge clock);
      ex_to_wb <= 1'b0;
    end
    await_finish();
    hold_result();
  endtask

  task automatic retire();
    @(posedge clock);
    ex_to_wb <= 1'b1;
    lsu_opt  <= 2'b00;
    @(posedge clock);
    ex_to_wb <= 1'b0;
  endtask

  always @(negedge clock) begin
    if (!reset && finished && !fin_prev && exp_load) begin
      word_compare("result_o", result, exp_result);
      checked++;
    end
    fin_prev = finished;
  end

  always @(negedge clock) begin
    if (UUT.u_props.fail_count != 0)
      abort_run("a bound AXI or request assertion failed");
  end

  initial begin
    logic [1:0]        size;
    logic              uns;
    logic [ADDR_W-1:0] a;
    void'($urandom(32'hb4fd_20aa));
    reset      = 1'b1;
    lsu_opt    = 2'b00;
    funct3     = 3'd0;
    addr       = '0;
    store_data = '0;
    ex_to_wb   = 1'b0;
    exp_load   = 1'b0;
    exp_result = '0;
    fin_prev   = 1'b0;
    loads      = 0;
    checked    = 0;
    for (int i = 0; i < MEM_WORDS*4; i++)
      shadow[i] = 8'h00;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    flag_compare("finished_o", finished, 1'b0);
    flag_compare("stall_o", stall, 1'b0);
    word_compare("result_o", result, '0);

    // untouched memory reads zero.
    for (int i = 0; i < 4; i++) begin
      issue(2'b01, 3'd2, $urandom & 32'hffff_fffc, '0, 1'b0);
      retire();
    end

    issue(2'b10, 3'd2, 32'h0000_0124, 32'hdead_beef, 1'b0);
    retire();
    issue(2'b01, 3'd2, 32'h0000_0124, '0, 1'b0);
    word_compare("result_o", result, 32'hdead_beef);
    retire();

    // narrow stores touch only their lanes.
    issue(2'b10, 3'd0, 32'h0000_0125, 32'h0000_005a, 1'b0);
    issue(2'b10, 3'd1, 32'h0000_0126, 32'h0000_1234, 1'b1);
    issue(2'b01, 3'd2, 32'h0000_0124, '0, 1'b1);
    word_compare("result_o", result, 32'h1234_5aef);
    retire();

    issue(2'b10, 3'd2, 32'h0000_0200, 32'h7c81_f401, 1'b0);
    for (int lane = 0; lane < 4; lane++) begin
      for (int u = 0; u < 2; u++) begin
        issue(2'b01, {u[0], F3_BYTE}, 32'h0000_0200 + lane, '0, 1'b1);
        if (lane % 2 == 0)
          issue(2'b01, {u[0], F3_HALF}, 32'h0000_0200 + lane, '0, 1'b1);
      end
    end
    retire();

    for (int i = 0; i < 300; i++) begin
      size = 2'($urandom_range(2, 0));
      uns  = 1'($urandom_range(1, 0));
      a    = $urandom & 32'hffff_fc1f;   // small window, so loads hit earlier stores.
      a    = a & ~((32'd1 << size) - 32'd1);
      if ($urandom_range(1, 0) == 1)
        issue(2'b01, {uns & (size != F3_WORD), size}, a, '0, i > 0);
      else
        issue(2'b10, {1'b0, size}, a, $urandom, i > 0);
    end
    retire();

    @(negedge clock);
    if (checked == loads && UUT.u_props.fail_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abort_run("load results were not all compared, or an assertion failed");
    end
  end

endmodule

`default_nettype wire

/* src.f */
verilog/lsu_pkg.sv
verilog/lsu_req_decode.sv
verilog/lsu_axil_master.sv
verilog/lsu_load_align.sv
verilog/axil_sram.sv
verilog/lsu_top.sv
tb/lsu_props.sv
tb/lsu_tb.sv
